// File: hw/stripe_pkg.sv
// Stripe sink package, shared widths, beat and command structs, controller states
`default_nettype none

package stripe_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  // Lane data width
  localparam int DATA_BITS = 64;
  // One keep bit per lane byte
  localparam int KEEP_BITS = DATA_BITS / 8;
  // Command length field, beats minus one
  localparam int LEN_BITS  = 12;

  // ----------------------------------------
  // Stream types
  // ----------------------------------------
  // Single lane beat, also used for user input and card row
  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic [KEEP_BITS-1:0] keep;
    logic                 last;
  } stripe_beat_t;

  // Transfer descriptor
  typedef struct packed {
    logic [LEN_BITS-1:0] len;   // beat count minus one
    logic                last;  // tlast on final row
  } stripe_cmd_t;

  // Controller FSM
  typedef enum logic [0:0] {
    ST_IDLE   = 1'b0,
    ST_STRIPE = 1'b1
  } stripe_state_e;

endpackage

`default_nettype wire

// File: hw/stripe_cmd_queue.sv
// Command queue, small circular FIFO of pending stripe transfer descriptors
`timescale 1ns/1ns
`default_nettype none

module stripe_cmd_queue
  import stripe_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic        aclk,
  input  logic        aresetn,
  input  stripe_cmd_t cmd_in,
  input  logic        cmd_in_valid,
  output logic        cmd_in_ready,
  output stripe_cmd_t cmd_out,
  output logic        cmd_out_valid,
  input  logic        cmd_out_ready
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  // Descriptor storage
  stripe_cmd_t         mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                push;
  logic                pop;

  // Wrap at DEPTH-1, depth need not be a power of two
  function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
    if (p == PTR_BITS'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // ----------------------------------------
  // Handshakes
  // ----------------------------------------
  assign cmd_in_ready  = (count != CNT_BITS'(DEPTH));
  assign cmd_out_valid = (count != '0);
  assign push          = cmd_in_valid && cmd_in_ready;
  assign pop           = cmd_out_valid && cmd_out_ready;

  // Head visible one cycle after push
  assign cmd_out = mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= cmd_in;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Full queue without a pop stays full, so no push slipped in
  assert property (@(posedge aclk) disable iff (!aresetn)
    (count == CNT_BITS'(DEPTH)) && !pop |=> (count == CNT_BITS'(DEPTH)));

endmodule

`default_nettype wire

// File: hw/stripe_ctrl.sv
// Stripe controller that deals user beats round-robin over lanes with padding and tlast
`timescale 1ns/1ns
`default_nettype none

module stripe_ctrl
  import stripe_pkg::*;
#(
  parameter int N_CHAN = 4
) (
  input  logic                       aclk,
  input  logic                       aresetn,
  input  stripe_cmd_t                cmd,
  input  logic                       cmd_valid,
  output logic                       cmd_ready,
  input  stripe_beat_t               user,
  input  logic                       user_valid,
  output logic                       user_ready,
  output stripe_beat_t [N_CHAN-1:0]  lane_wr,
  output logic [N_CHAN-1:0]          lane_wr_valid,
  input  logic [N_CHAN-1:0]          lane_wr_ready
);

  localparam int SEL_BITS  = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;
  // Beat index to row index
  localparam int ROW_SHIFT = $clog2(N_CHAN);

  stripe_state_e        state;
  logic [LEN_BITS-1:0]  cnt;
  logic [LEN_BITS-1:0]  n_beats;
  logic                 cmd_last;
  logic [SEL_BITS-1:0]  sel;

  logic                 xfer;
  logic                 done;
  logic                 take;
  logic                 final_row;
  logic [N_CHAN-1:0]    data_lane;

  // ----------------------------------------
  // Handshakes
  // ----------------------------------------
  // Any full lane stalls the whole user stream
  assign user_ready = (state == ST_STRIPE) && (&lane_wr_ready);
  assign xfer       = user_valid && user_ready;
  assign done       = xfer && (cnt == n_beats);
  // Next command on the final beat keeps transfers back to back
  assign cmd_ready  = (state == ST_IDLE) || done;
  assign take       = cmd_valid && cmd_ready;

  // Rows restart at lane 0, so row of beat = cnt / N_CHAN
  assign final_row = (cnt >> ROW_SHIFT) == (n_beats >> ROW_SHIFT);

  // ----------------------------------------
  // FSM and counters
  // ----------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state    <= ST_IDLE;
      cnt      <= '0;
      n_beats  <= '0;
      cmd_last <= 1'b0;
      sel      <= '0;
    end else if (take) begin
      state    <= ST_STRIPE;
      cnt      <= '0;
      n_beats  <= cmd.len;
      cmd_last <= cmd.last;
      sel      <= '0;
    end else if (done) begin
      state <= ST_IDLE;
      cnt   <= '0;
      sel   <= '0;
    end else if (xfer) begin
      cnt <= cnt + 1'b1;
      // Wrap after the top lane
      if (sel == SEL_BITS'(N_CHAN - 1)) begin
        sel <= '0;
      end else begin
        sel <= sel + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Lane routing
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < N_CHAN; i++) begin
      lane_wr_valid[i] = 1'b0;
      lane_wr[i].data  = '0;
      lane_wr[i].keep  = '0;
      // Whole final row tagged including earlier lanes
      lane_wr[i].last  = cmd_last && final_row;
      if (xfer && (sel == SEL_BITS'(i))) begin
        // Selected lane takes the user beat
        lane_wr_valid[i] = 1'b1;
        lane_wr[i].data  = user.data;
        lane_wr[i].keep  = user.keep;
      end else if (done && (SEL_BITS'(i) > sel)) begin
        // Keep-zero padding above the final beat
        lane_wr_valid[i] = 1'b1;
      end
    end
  end

  // Lanes carrying real data this cycle
  always_comb begin
    for (int i = 0; i < N_CHAN; i++) begin
      data_lane[i] = lane_wr_valid[i] && (|lane_wr[i].keep);
    end
  end

  // Lane select in step with the beat count, count within the length
  assert property (@(posedge aclk) disable iff (!aresetn)
    (state == ST_STRIPE) |-> (cnt <= n_beats) && (sel == SEL_BITS'(cnt % N_CHAN)));

  // Only one lane gets payload per cycle and the rest are padding
  assert property (@(posedge aclk) disable iff (!aresetn)
    $onehot0(data_lane));

endmodule

`default_nettype wire

// File: hw/lane_fifo.sv
// Lane FIFO, per-lane beat buffer between controller and card row merge
`timescale 1ns/1ns
`default_nettype none

module lane_fifo
  import stripe_pkg::*;
#(
  // Power of two, at least 2
  parameter int DEPTH = 8
) (
  input  logic         aclk,
  input  logic         aresetn,
  input  stripe_beat_t wr,
  input  logic         wr_valid,
  output logic         wr_ready,
  output stripe_beat_t rd,
  output logic         rd_valid,
  input  logic         rd_ready
);

  localparam int ADDR_BITS = $clog2(DEPTH);

  stripe_beat_t         mem [DEPTH];
  // Extra MSB so used can reach DEPTH
  logic [ADDR_BITS:0]   wr_ptr;
  logic [ADDR_BITS:0]   rd_ptr;
  logic [ADDR_BITS:0]   used;
  logic                 wr_en;
  logic                 rd_en;

  // ----------------------------------------
  // Status
  // ----------------------------------------
  assign used     = wr_ptr - rd_ptr;
  assign wr_ready = (used != (ADDR_BITS + 1)'(DEPTH));
  assign rd_valid = (used != '0);
  assign wr_en    = wr_valid && wr_ready;
  assign rd_en    = rd_valid && rd_ready;

  // Head valid the cycle after the write
  assign rd = mem[rd_ptr[ADDR_BITS-1:0]];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr[ADDR_BITS-1:0]] <= wr;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy bounded, no write ever landed on a full FIFO
  assert property (@(posedge aclk) disable iff (!aresetn)
    used <= (ADDR_BITS + 1)'(DEPTH));

endmodule

`default_nettype wire

// File: hw/card_row_merge.sv
// Card row merge, joins all lane FIFO heads into one registered wide row
`timescale 1ns/1ns
`default_nettype none

module card_row_merge
  import stripe_pkg::*;
#(
  parameter int N_CHAN = 4
) (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  stripe_beat_t [N_CHAN-1:0] lane,
  input  logic [N_CHAN-1:0]         lane_valid,
  output logic [N_CHAN-1:0]         lane_ready,
  output stripe_beat_t [N_CHAN-1:0] card,
  output logic                      card_valid,
  input  logic                      card_ready
);

  logic load;

  // Full row present and output slot free or draining
  assign load       = (&lane_valid) && (!card_valid || card_ready);
  // Pop every lane together
  assign lane_ready = {N_CHAN{load}};

  // Row payload
  always_ff @(posedge aclk) begin
    if (load) begin
      card <= lane;
    end
  end

  // ----------------------------------------
  // Output valid
  // ----------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      card_valid <= 1'b0;
    end else if (load) begin
      card_valid <= 1'b1;
    end else if (card_ready) begin
      card_valid <= 1'b0;
    end
  end

  // Stalled row holds
  assert property (@(posedge aclk) disable iff (!aresetn)
    card_valid && !card_ready |=> card_valid && $stable(card));

endmodule

`default_nettype wire

// File: hw/stripe_sink_top.sv
// Stripe sink top, command queue, stripe controller, lane FIFOs and card row merge
`timescale 1ns/1ns
`default_nettype none

module stripe_sink_top
  import stripe_pkg::*;
#(
  parameter int N_CHAN     = 4,
  parameter int CMD_DEPTH  = 4,
  parameter int LANE_DEPTH = 8
) (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  stripe_cmd_t               cmd,
  input  logic                      cmd_valid,
  output logic                      cmd_ready,
  input  stripe_beat_t              user,
  input  logic                      user_valid,
  output logic                      user_ready,
  output stripe_beat_t [N_CHAN-1:0] card,
  output logic                      card_valid,
  input  logic                      card_ready
);

  // Queue to controller
  stripe_cmd_t               cmd_q;
  logic                      cmd_q_valid;
  logic                      cmd_q_ready;
  // Controller to lane FIFOs
  stripe_beat_t [N_CHAN-1:0] lane_wr;
  logic [N_CHAN-1:0]         lane_wr_valid;
  logic [N_CHAN-1:0]         lane_wr_ready;
  // Lane FIFOs to merge
  stripe_beat_t [N_CHAN-1:0] lane_rd;
  logic [N_CHAN-1:0]         lane_rd_valid;
  logic [N_CHAN-1:0]         lane_rd_ready;

  stripe_cmd_queue #(
    .DEPTH (CMD_DEPTH)
  ) u_cmd_queue (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .cmd_in        (cmd),
    .cmd_in_valid  (cmd_valid),
    .cmd_in_ready  (cmd_ready),
    .cmd_out       (cmd_q),
    .cmd_out_valid (cmd_q_valid),
    .cmd_out_ready (cmd_q_ready)
  );

  stripe_ctrl #(
    .N_CHAN (N_CHAN)
  ) u_ctrl (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .cmd           (cmd_q),
    .cmd_valid     (cmd_q_valid),
    .cmd_ready     (cmd_q_ready),
    .user          (user),
    .user_valid    (user_valid),
    .user_ready    (user_ready),
    .lane_wr       (lane_wr),
    .lane_wr_valid (lane_wr_valid),
    .lane_wr_ready (lane_wr_ready)
  );

  // ----------------------------------------
  // One FIFO per memory channel lane
  // ----------------------------------------
  for (genvar i = 0; i < N_CHAN; i++) begin : g_lane
    lane_fifo #(
      .DEPTH (LANE_DEPTH)
    ) u_lane_fifo (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .wr       (lane_wr[i]),
      .wr_valid (lane_wr_valid[i]),
      .wr_ready (lane_wr_ready[i]),
      .rd       (lane_rd[i]),
      .rd_valid (lane_rd_valid[i]),
      .rd_ready (lane_rd_ready[i])
    );
  end

  card_row_merge #(
    .N_CHAN (N_CHAN)
  ) u_merge (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .lane       (lane_rd),
    .lane_valid (lane_rd_valid),
    .lane_ready (lane_rd_ready),
    .card       (card),
    .card_valid (card_valid),
    .card_ready (card_ready)
  );

endmodule

`default_nettype wire

// File: sim/tb_stripe_sink.sv
// Stripe sink testbench, LFSR traffic against a row model of the striping rule
`timescale 1ns/1ns
`default_nettype none

module tb_stripe_sink
  import stripe_pkg::*;
();

  localparam int N_CHAN         = 4;
  localparam int CMD_DEPTH      = 4;
  localparam int LANE_DEPTH     = 8;
  localparam int TIMEOUT_CYCLES = 3000;

  typedef stripe_beat_t [N_CHAN-1:0] row_t;

  logic         aclk;
  logic         aresetn;
  stripe_cmd_t  cmd;
  logic         cmd_valid;
  logic         cmd_ready;
  stripe_beat_t user;
  logic         user_valid;
  logic         user_ready;
  row_t         card;
  logic         card_valid;
  logic         card_ready;

  // Stimulus and model state
  logic [31:0]  lfsr;
  logic         user_gaps;
  logic         card_stall;
  stripe_cmd_t  cmd_q[$];
  stripe_beat_t user_q[$];
  row_t         exp_q[$];
  int           errors;
  int           rows_checked;
  int           tests_run;
  logic [63:0]  rnd;
  int           n;

  stripe_sink_top #(
    .N_CHAN     (N_CHAN),
    .CMD_DEPTH  (CMD_DEPTH),
    .LANE_DEPTH (LANE_DEPTH)
  ) dut (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .user       (user),
    .user_valid (user_valid),
    .user_ready (user_ready),
    .card       (card),
    .card_valid (card_valid),
    .card_ready (card_ready)
  );

  initial aclk = 1'b0;
  always #2 aclk = ~aclk;

  // Stalled card row must hold
  assert property (@(posedge aclk) disable iff (!aresetn)
    card_valid && !card_ready |=> card_valid && $stable(card))
  else begin
    $display("CHECK FAILED t=%0t card row changed while stalled", $time);
    errors++;
  end

  // ----------------------------------------
  // Random source
  // ----------------------------------------
  // Fibonacci taps 32 22 2 1, one step per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_bits(input int nbits);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      v = {v[62:0], lfsr_bit()};
    end
    return v;
  endfunction

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  // Queue one command, its user beats and the rows it should produce
  task automatic plan_transfer(input int beats, input logic last);
    stripe_cmd_t  c;
    stripe_beat_t b;
    row_t         row;
    int           lane;
    c.len  = LEN_BITS'(beats - 1);
    c.last = last;
    cmd_q.push_back(c);
    row  = '0;
    lane = 0;
    for (int i = 0; i < beats; i++) begin
      b.data = rand_bits(DATA_BITS);
      b.keep = '1;
      // User last is ignored by the DUT
      b.last = lfsr_bit();
      user_q.push_back(b);
      row[lane].data = b.data;
      row[lane].keep = b.keep;
      lane++;
      if (i == beats - 1) begin
        // Final row, padding lanes stay keep zero
        for (int l = 0; l < N_CHAN; l++) begin
          row[l].last = last;
        end
      end
      if (lane == N_CHAN || i == beats - 1) begin
        exp_q.push_back(row);
        row  = '0;
        lane = 0;
      end
    end
  endtask

  // Padding data is don't care
  function automatic logic row_matches(input row_t got, input row_t want);
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < N_CHAN; i++) begin
      if (got[i].keep !== want[i].keep || got[i].last !== want[i].last) begin
        ok = 1'b0;
      end
      if (want[i].keep != '0 && got[i].data !== want[i].data) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  task automatic check_row();
    row_t              want;
    logic [N_CHAN-1:0] lasts;
    for (int i = 0; i < N_CHAN; i++) begin
      lasts[i] = card[i].last;
    end
    assert ((&lasts) || !(|lasts)) else begin
      $display("CHECK FAILED t=%0t last set on only some lanes: %b", $time, lasts);
      errors++;
    end
    assert (exp_q.size() != 0) else begin
      $display("Extra card row at %0t that the model does not expect", $time);
      errors++;
    end
    if (exp_q.size() != 0) begin
      want = exp_q.pop_front();
      assert (row_matches(card, want)) else begin
        $display("CHECK FAILED t=%0t row %0d got %h expected %h",
                 $time, rows_checked, card, want);
        errors++;
      end
      rows_checked++;
    end
  endtask

  // ----------------------------------------
  // Traffic engine
  // ----------------------------------------
  // Drive on the falling edge, sample 1 ns later when all is settled
  task automatic run_traffic(input string name);
    int   cycles;
    int   err_before;
    int   rows_before;
    logic u_hold;
    err_before  = errors;
    rows_before = rows_checked;
    cycles      = 0;
    u_hold      = 1'b0;
    while ((cmd_q.size() != 0 || user_q.size() != 0 || exp_q.size() != 0)
           && cycles < TIMEOUT_CYCLES) begin
      @(negedge aclk);
      cycles++;
      cmd_valid = (cmd_q.size() != 0);
      if (cmd_valid) begin
        cmd = cmd_q[0];
      end
      // Valid held until the beat is taken
      if (!u_hold) begin
        user_valid = (user_q.size() != 0) && (!user_gaps || rand_bits(2) != '0);
      end
      if (user_valid) begin
        user = user_q[0];
      end
      card_ready = card_stall ? (rand_bits(2) == '0) : 1'b1;
      #1;
      if (cmd_valid && cmd_ready) begin
        void'(cmd_q.pop_front());
      end
      u_hold = user_valid && !user_ready;
      if (user_valid && user_ready) begin
        void'(user_q.pop_front());
      end
      if (card_valid && card_ready) begin
        check_row();
      end
    end
    if (exp_q.size() != 0 || user_q.size() != 0 || cmd_q.size() != 0) begin
      $display("Test %s timed out after %0d cycles with %0d rows still missing",
               name, cycles, exp_q.size());
      $display("STATUS: FAIL");
      $finish;
    end
    // Quiet tail, nothing more may come out
    for (int i = 0; i < 6; i++) begin
      @(negedge aclk);
      cmd_valid  = 1'b0;
      user_valid = 1'b0;
      card_ready = 1'b1;
      #1;
      if (card_valid) begin
        check_row();
      end
      assert (!user_ready) else begin
        $display("CHECK FAILED t=%0t user_ready high with no command", $time);
        errors++;
      end
    end
    tests_run++;
    $display("Test %s done: %0d rows, %0d errors", name,
             rows_checked - rows_before, errors - err_before);
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    aresetn      = 1'b0;
    cmd          = '0;
    cmd_valid    = 1'b0;
    user         = '0;
    user_valid   = 1'b0;
    card_ready   = 1'b0;
    lfsr         = 32'hec16_a600;
    user_gaps    = 1'b0;
    card_stall   = 1'b0;
    errors       = 0;
    rows_checked = 0;
    tests_run    = 0;
    repeat (5) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
    #1;

    // Idle outputs out of reset
    assert (cmd_ready && !user_ready && !card_valid) else begin
      $display("CHECK FAILED t=%0t reset state cmd_ready %b user_ready %b card_valid %b",
               $time, cmd_ready, user_ready, card_valid);
      errors++;
    end
    tests_run++;
    $display("Test reset_state done: %0d errors", errors);

    // Whole rows only
    plan_transfer(4, 1'b0);
    plan_transfer(8, 1'b0);
    plan_transfer(12, 1'b0);
    run_traffic("full_rows");

    // Short final rows get padding
    plan_transfer(1, 1'b0);
    plan_transfer(2, 1'b0);
    plan_transfer(3, 1'b0);
    plan_transfer(5, 1'b0);
    plan_transfer(7, 1'b0);
    run_traffic("padded_rows");

    // tlast, top lane endings included
    plan_transfer(4, 1'b1);
    plan_transfer(6, 1'b1);
    plan_transfer(3, 1'b0);
    plan_transfer(8, 1'b1);
    plan_transfer(1, 1'b1);
    run_traffic("last_flag");

    // Heavy card stalls fill the lanes
    user_gaps  = 1'b1;
    card_stall = 1'b1;
    for (int t = 0; t < 12; t++) begin
      rnd = rand_bits(4);
      n   = int'(rnd % 64'd9) + 1;
      rnd = rand_bits(1);
      plan_transfer(n, rnd[0]);
    end
    run_traffic("backpressure");

    // Commands piled up ahead of the data
    user_gaps  = 1'b0;
    card_stall = 1'b0;
    for (int t = 0; t < 8; t++) begin
      rnd = rand_bits(4);
      n   = int'(rnd % 64'd9) + 1;
      rnd = rand_bits(1);
      plan_transfer(n, rnd[0]);
    end
    run_traffic("back_to_back");

    $display("Tests run %0d, rows checked %0d, errors %0d", tests_run, rows_checked, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
hw/stripe_pkg.sv
hw/stripe_cmd_queue.sv
hw/stripe_ctrl.sv
hw/lane_fifo.sv
hw/card_row_merge.sv
hw/stripe_sink_top.sv
sim/tb_stripe_sink.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_stripe_sink
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
